// File: verilog.f
design/chnbuf_pkg.sv
design/chnbuf_reg.sv
design/chnbuf_page_ram.sv
design/chnbuf_reader.sv
design/chnbuf_fanout_top.sv
verif/tb_clock.sv
verif/chnbuf_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the channel buffer testbench with Verilator and run it
# exit status is 0 only when the pass message shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f verilog.f \
    --top-module chnbuf_tb -Mdir obj_dir -o chnbuf_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/chnbuf_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Test completed successfully"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: verif/chnbuf_tb.sv
// testbench top for the channel buffer fan-out
// reference model of all channel buffers with its own page and word pointers
// directed tests: reset, single fill, interleaved tags, page advance, wrap, read port
// compare tasks for data words and page indices, LCG for write data, watchdog
`default_nettype none

module chnbuf_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period       = 20;
    localparam int reset_cycles     = 8;
    localparam int interleave_words = 40;  // random-tag writes in the interleave test
    localparam int adv_words        = 8;   // words written after a page advance
    localparam int wrap_words       = chnbuf_pkg::page_words + 8;
    localparam int rsp_timeout      = 4;   // cycles to wait for valid
    localparam int read_cycles      = 6;   // one read with its checks, rounded up
    localparam int verify_calls     = 9;   // channel read-backs over all tests
    // two cycles per written word plus two per page pulse, generous
    localparam int write_budget = 2 * (chnbuf_pkg::page_words + interleave_words
        + 2 * adv_words + wrap_words + 8) + 4 * (chnbuf_pkg::page_count + 3);
    localparam int test_cycles = reset_cycles + 20 + write_budget
        + read_cycles * (verify_calls * chnbuf_pkg::page_count * chnbuf_pkg::page_words + 3);
    localparam int watchdog_cycles = test_cycles + 500;

    logic                rst;     // clock
    logic                clk;     // reset, active low
    chnbuf_pkg::ext_wr_t ext_wr;  // controller bus, driven by the tests
    chnbuf_pkg::rd_req_t rd_req;
    chnbuf_pkg::rd_rsp_t rd_rsp;
    chnbuf_pkg::page_t [chnbuf_pkg::chn_count-1:0] wpage_all;

    // reference model
    chnbuf_pkg::data_t mdl_mem
        [chnbuf_pkg::chn_count][chnbuf_pkg::page_count][chnbuf_pkg::page_words];
    bit mdl_written
        [chnbuf_pkg::chn_count][chnbuf_pkg::page_count][chnbuf_pkg::page_words];
    int mdl_page [chnbuf_pkg::chn_count];  // page being filled
    int mdl_word [chnbuf_pkg::chn_count];  // next word in that page

    int          err_count   = 0;
    int          check_count = 0;
    logic [31:0] lcg_state   = 32'he901;

    tb_clock #(.half_period(clk_period / 2)) tb_clock_i (.rst(rst));

    chnbuf_fanout_top chnbuf_fanout_top_i (
        .rst       (rst),
        .clk       (clk),
        .ext_wr    (ext_wr),
        .rd_req    (rd_req),
        .rd_rsp    (rd_rsp),
        .wpage_all (wpage_all)
    );

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;  // numerical recipes LCG
        return lcg_state;
    endfunction

    function automatic chnbuf_pkg::data_t random_data();
        return {next_random(), next_random()};
    endfunction

    // word lands at the pointers, word pointer wraps inside the page
    function automatic void model_write(input int c, input chnbuf_pkg::data_t d);
        mdl_mem[c][mdl_page[c]][mdl_word[c]]     = d;
        mdl_written[c][mdl_page[c]][mdl_word[c]] = 1'b1;
        mdl_word[c] = (mdl_word[c] + 1) % chnbuf_pkg::page_words;
    endfunction

    function automatic void model_page_step(input int c);
        mdl_page[c] = (mdl_page[c] + 1) % chnbuf_pkg::page_count;
        mdl_word[c] = 0;  // new page starts at word 0
    endfunction

    task automatic compare_data(input string name, input chnbuf_pkg::data_t got,
                                input chnbuf_pkg::data_t exp);
        check_count++;
        if (got !== exp) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic compare_page(input string name, input chnbuf_pkg::page_t got,
                                input chnbuf_pkg::page_t exp);
        check_count++;
        if (got !== exp) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            err_count++;
        end
    endtask

    // tag cycle, then one strobe cycle; the next task drops wr
    task automatic write_word(input int c, input chnbuf_pkg::data_t d);
        @(posedge rst);
        ext_wr.wr        <= 1'b0;
        ext_wr.wpage_nxt <= 1'b0;
        ext_wr.wchn      <= chnbuf_pkg::chn_t'(c);
        @(posedge rst);
        ext_wr.wr    <= 1'b1;
        ext_wr.wdata <= d;
        model_write(c, d);
    endtask

    // tag cycle, n strobes back to back with the tag held, then idle
    task automatic write_burst(input int c, input int n);
        chnbuf_pkg::data_t d;
        @(posedge rst);
        ext_wr.wr        <= 1'b0;
        ext_wr.wpage_nxt <= 1'b0;
        ext_wr.wchn      <= chnbuf_pkg::chn_t'(c);
        repeat (n) begin
            d = random_data();
            @(posedge rst);
            ext_wr.wr    <= 1'b1;
            ext_wr.wdata <= d;
            model_write(c, d);
        end
        @(posedge rst);
        ext_wr.wr <= 1'b0;
    endtask

    // one-cycle pulse, sampled with the tag of the same cycle
    task automatic page_advance(input int c);
        @(posedge rst);
        ext_wr.wr        <= 1'b0;
        ext_wr.wpage_nxt <= 1'b1;
        ext_wr.wchn      <= chnbuf_pkg::chn_t'(c);
        @(posedge rst);
        ext_wr.wpage_nxt <= 1'b0;
        model_page_step(c);
    endtask

    task automatic check_pages();
        @(negedge rst);  // page pointers only move on the rising edge
        for (int c = 0; c < chnbuf_pkg::chn_count; c++) begin
            compare_page($sformatf("wpage_all[%0d]", c), wpage_all[c],
                         chnbuf_pkg::page_t'(mdl_page[c]));
        end
    endtask

    // request for one cycle, wait for valid, check data and valid width
    task automatic read_check(input int c, input int p, input int w,
                              input chnbuf_pkg::data_t exp);
        int waited;
        @(posedge rst);
        ext_wr.wr        <= 1'b0;
        ext_wr.wpage_nxt <= 1'b0;
        rd_req.rd        <= 1'b1;
        rd_req.chn       <= chnbuf_pkg::chn_t'(c);
        rd_req.page      <= chnbuf_pkg::page_t'(p);
        rd_req.word      <= chnbuf_pkg::word_t'(w);
        @(posedge rst);
        rd_req.rd <= 1'b0;  // DUT takes the request at this edge
        waited = 0;
        @(negedge rst);
        while (!rd_rsp.valid && waited < rsp_timeout) begin
            waited++;
            @(negedge rst);
        end
        if (!rd_rsp.valid) begin
            $display("no read response for channel %0d page %0d word %0d", c, p, w);
            err_count++;
        end else begin
            if (waited != 0) begin
                $display("read response for channel %0d came %0d cycles late", c, waited);
                err_count++;
            end
            compare_data($sformatf("rd_rsp.data ch%0d page%0d word%0d", c, p, w),
                         rd_rsp.data, exp);
            @(negedge rst);
            if (rd_rsp.valid) begin
                $display("read valid for channel %0d stayed high past one cycle", c);
                err_count++;
            end
        end
    endtask

    // read back every word the model has seen for one channel
    task automatic verify_channel(input int c);
        for (int p = 0; p < chnbuf_pkg::page_count; p++) begin
            for (int w = 0; w < chnbuf_pkg::page_words; w++) begin
                if (mdl_written[c][p][w]) begin
                    read_check(c, p, w, mdl_mem[c][p][w]);
                end
            end
        end
    endtask

    task automatic test_reset();
        check_pages();  // all pages zero after reset
        repeat (10) begin
            @(negedge rst);
            if (rd_rsp.valid) begin
                $display("read valid seen after reset with no request");
                err_count++;
            end
        end
    endtask

    task automatic test_single_fill();
        write_burst(2, chnbuf_pkg::page_words);
        check_pages();  // a full page does not move the page pointer
        verify_channel(2);
    endtask

    task automatic test_interleave();
        int tag;
        repeat (interleave_words) begin
            tag = int'(next_random() >> 30);  // upper bits, 0 to 3
            write_word(tag, random_data());
        end
        for (int c = 0; c < chnbuf_pkg::chn_count; c++) begin
            verify_channel(c);
        end
    endtask

    task automatic test_page_advance();
        page_advance(1);
        page_advance(3);
        check_pages();  // only channels 1 and 3 step
        write_burst(1, adv_words);
        write_burst(3, adv_words);
        verify_channel(1);  // old page 0 and new page 1
        verify_channel(3);
    endtask

    task automatic test_wrap();
        write_burst(0, wrap_words);  // past the end of the page
        verify_channel(0);
        repeat (chnbuf_pkg::page_count + 1) page_advance(0);
        check_pages();
        write_burst(0, 4);
        verify_channel(0);
    endtask

    task automatic test_read_port();
        read_check(4, 0, 0, '0);    // first tag past the last channel
        read_check(15, 1, 0, '0);   // low tag bits point at a written word of channel 3
        read_check(2, 0, 5, mdl_mem[2][0][5]);
    endtask

    initial begin
        clk    <= 1'b0;  // reset asserted from time 0
        ext_wr <= '0;
        rd_req <= '0;
        for (int c = 0; c < chnbuf_pkg::chn_count; c++) begin
            mdl_page[c] = 0;
            mdl_word[c] = 0;
        end
        repeat (reset_cycles) @(posedge rst);
        clk <= 1'b1;

        test_reset();
        test_single_fill();
        test_interleave();
        test_page_advance();
        test_wrap();
        test_read_port();

        repeat (2) @(posedge rst);
        $display("summary: %0d checks, %0d errors", check_count, err_count);
        if (err_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // upper bound on run time from the test lengths above
    initial begin
        #(watchdog_cycles * clk_period);
        $display("watchdog expired after %0d cycles, tests did not finish", watchdog_cycles);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/tb_clock.sv
// testbench clock generator
// free-running square wave, 20 ns period by default
`default_nettype none

module tb_clock #(
    parameter int half_period = 10  // ns, half of the clock period
) (
    output logic rst  // clock, named like the DUT port it drives
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        rst = 1'b0;
        forever #(half_period) rst = ~rst;  // first rising edge at half_period
    end

endmodule

`default_nettype wire

// File: design/chnbuf_fanout_top.sv
// top level of the read-data fan-out
// one decode stage and one paged buffer per channel, built in a generate loop
// one shared registered read port over all buffers
// write pages of all channels exported as wpage_all
`default_nettype none

module chnbuf_fanout_top (
    input  wire                 rst,     // clock
    input  wire                 clk,     // async reset, active low
    input  chnbuf_pkg::ext_wr_t ext_wr,  // shared bus from the controller
    input  chnbuf_pkg::rd_req_t rd_req,  // consumer read request
    output chnbuf_pkg::rd_rsp_t rd_rsp,  // response, one cycle after the request
    output chnbuf_pkg::page_t [chnbuf_pkg::chn_count-1:0] wpage_all  // fill page per channel
);

    // per-channel write paths, falling-edge timed
    chnbuf_pkg::chn_wr_t chn_wr [chnbuf_pkg::chn_count];

    // combinational read words, one per buffer
    chnbuf_pkg::data_t [chnbuf_pkg::chn_count-1:0] buf_data;

    genvar i;
    generate
        for (i = 0; i < chnbuf_pkg::chn_count; i++) begin : g_chn

            // decode: own tag only
            chnbuf_reg #(
                .chn_num (chnbuf_pkg::chn_t'(i))
            ) chnbuf_reg_i (
                .rst    (rst),
                .clk    (clk),
                .ext_wr (ext_wr),
                .chn_wr (chn_wr[i])
            );

            // execute: paged buffer, read index shared by all channels
            chnbuf_page_ram chnbuf_page_ram_i (
                .rst     (rst),
                .clk     (clk),
                .chn_wr  (chn_wr[i]),
                .rd_page (rd_req.page),
                .rd_word (rd_req.word),
                .rd_data (buf_data[i]),
                .wpage   (wpage_all[i])
            );

        end
    endgenerate

    // result: picks the requested channel and registers it
    chnbuf_reader chnbuf_reader_i (
        .rst      (rst),
        .clk      (clk),
        .rd_req   (rd_req),
        .buf_data (buf_data),
        .rd_rsp   (rd_rsp)
    );

endmodule

`default_nettype wire

// File: design/chnbuf_reader.sv
// result stage: shared registered read port
// selects the addressed channel among all buffer read words
// valid follows every request for exactly one cycle
`default_nettype none

module chnbuf_reader (
    input  wire                 rst,     // clock
    input  wire                 clk,     // async reset, active low
    input  chnbuf_pkg::rd_req_t rd_req,  // page/word go straight to the buffers
    input  chnbuf_pkg::data_t [chnbuf_pkg::chn_count-1:0] buf_data,  // one per channel
    output chnbuf_pkg::rd_rsp_t rd_rsp
);

    chnbuf_pkg::data_t sel_data;  // word of the requested channel
    chnbuf_pkg::data_t data_q;    // registered response word
    logic              valid_q;   // registered response strobe

    // channel mux, tags past the last channel fall through to zero
    always_comb begin
        sel_data = '0;
        for (int i = 0; i < chnbuf_pkg::chn_count; i++) begin
            if (rd_req.chn == chnbuf_pkg::chn_t'(i)) begin
                sel_data = buf_data[i];
            end
        end
    end

    // valid is the request strobe one clock later
    // a back-to-back request gives back-to-back single-cycle valids
    always_ff @(posedge rst or negedge clk) begin
        if (!clk) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= rd_req.rd;
        end
    end

    // response word only loads on a request
    always_ff @(posedge rst) begin
        if (rd_req.rd) begin
            data_q <= sel_data;
        end
    end

    assign rd_rsp = '{
        valid: valid_q,
        data:  data_q
    };

endmodule

`default_nettype wire

// File: design/chnbuf_page_ram.sv
// execute stage: paged buffer of one channel
// write side keeps a word pointer and a page pointer
// read side is combinational at any page and word
// current write page is exported for the consumer
`default_nettype none

module chnbuf_page_ram (
    input  wire                 rst,      // clock
    input  wire                 clk,      // async reset, active low
    input  chnbuf_pkg::chn_wr_t chn_wr,   // from the decode stage, falling-edge timed
    input  chnbuf_pkg::page_t   rd_page,  // read page index
    input  chnbuf_pkg::word_t   rd_word,  // read word index
    output chnbuf_pkg::data_t   rd_data,  // word at rd_page / rd_word
    output chnbuf_pkg::page_t   wpage     // page currently being filled
);

    // last index values, used for the wrap of each pointer
    localparam chnbuf_pkg::word_t word_last =
        chnbuf_pkg::word_t'(chnbuf_pkg::page_words - 1);
    localparam chnbuf_pkg::page_t page_last =
        chnbuf_pkg::page_t'(chnbuf_pkg::page_count - 1);

    // storage: page_count pages of page_words words each
    chnbuf_pkg::data_t mem [chnbuf_pkg::page_count][chnbuf_pkg::page_words];

    chnbuf_pkg::word_t word_ptr;   // next word to write in the current page
    chnbuf_pkg::page_t page_ptr;   // page being filled
    chnbuf_pkg::word_t word_inc;   // word pointer plus one, wrapped
    chnbuf_pkg::page_t page_inc;   // page pointer plus one, wrapped

    // wrap at page_words, a long burst stays in the same page
    always_comb begin
        if (word_ptr == word_last) begin
            word_inc = '0;
        end else begin
            word_inc = word_ptr + 1'b1;
        end
    end

    // page advance is modulo page_count
    always_comb begin
        if (page_ptr == page_last) begin
            page_inc = '0;
        end else begin
            page_inc = page_ptr + 1'b1;
        end
    end

    // pointer update on the rising edge after the strobe
    always_ff @(posedge rst or negedge clk) begin
        if (!clk) begin
            word_ptr <= '0;
            page_ptr <= '0;
        end else begin
            if (chn_wr.wpage_nxt) begin
                // new page always starts at word 0
                page_ptr <= page_inc;
                word_ptr <= '0;
            end else if (chn_wr.wr) begin
                word_ptr <= word_inc;  // one step per written word
            end
        end
    end

    // a write in the same cycle as a page pulse still lands in the old page
    always_ff @(posedge rst) begin
        if (chn_wr.wr) begin
            mem[page_ptr][word_ptr] <= chn_wr.wdata;
        end
    end

    // asynchronous read, the reader registers it
    assign rd_data = mem[rd_page][rd_word];

    assign wpage = page_ptr;  // visible outside as wpage_all

endmodule

`default_nettype wire

// File: design/chnbuf_reg.sv
// decode stage for one channel
// picks the words of its own channel off the shared controller bus
// and re-times strobe, page pulse and data on the falling clock edge
`default_nettype none

module chnbuf_reg #(
    parameter chnbuf_pkg::chn_t chn_num = '0  // channel this stage answers to
) (
    input  wire                 rst,     // clock
    input  wire                 clk,     // async reset, active low
    input  chnbuf_pkg::ext_wr_t ext_wr,  // shared controller bus
    output chnbuf_pkg::chn_wr_t chn_wr   // falling-edge write path for the buffer
);

    logic              chn_sel;   // tag matched on the previous falling edge
    logic              wr_q;      // qualified write strobe
    logic              nxt_q;     // qualified page advance
    chnbuf_pkg::data_t wdata_q;   // held write word
    logic              tag_hit;   // tag on the bus is ours this cycle

    assign tag_hit = (ext_wr.wchn == chn_num);

    // control path
    // the tag runs one clock ahead of wr, so the match is kept
    // for a cycle and then gates the strobe
    always_ff @(negedge rst or negedge clk) begin
        if (!clk) begin
            chn_sel <= 1'b0;
            wr_q    <= 1'b0;
            nxt_q   <= 1'b0;
        end else begin
            chn_sel <= tag_hit;                  // match of cycle n
            wr_q    <= chn_sel && ext_wr.wr;     // wr of cycle n+1
            nxt_q   <= tag_hit && ext_wr.wpage_nxt;  // same-cycle tag
        end
    end

    // data only moves when the strobe qualifies, otherwise it holds
    always_ff @(negedge rst) begin
        if (chn_sel && ext_wr.wr) begin
            wdata_q <= ext_wr.wdata;
        end
    end

    // buffer samples these on the next rising edge, half a cycle later
    assign chn_wr = '{
        wr:        wr_q,
        wpage_nxt: nxt_q,
        wdata:     wdata_q
    };

endmodule

`default_nettype wire

// File: design/chnbuf_pkg.sv
// shared definitions for the channel buffer fan-out
// geometry localparams: channels, pages per channel, words per page
// width typedefs for tags, data words, page and word indices
// packed structs for the controller write bus, per-channel write path,
// and the read request / response pair
`default_nettype none

package chnbuf_pkg;

    // buffer geometry
    localparam int chn_count  = 4;   // channels served by the fan-out
    localparam int page_count = 4;   // pages in each channel buffer
    localparam int page_words = 32;  // 64-bit words in one page

    typedef logic [3:0]  chn_t;   // channel tag as sent by the controller
    typedef logic [63:0] data_t;  // one data word
    typedef logic [1:0]  page_t;  // page index inside a channel buffer
    typedef logic [4:0]  word_t;  // word address inside a page

    // shared controller bus, 70 bits
    // wchn leads wr by one clock and holds while wr is high
    typedef struct packed {
        logic  wr;         // write strobe
        logic  wpage_nxt;  // page advance pulse, paired with wchn of the same cycle
        chn_t  wchn;       // target channel
        data_t wdata;      // valid together with wr
    } ext_wr_t;

    // one channel's write path after the register stage, 66 bits
    typedef struct packed {
        logic  wr;
        logic  wpage_nxt;
        data_t wdata;
    } chn_wr_t;

    // read request from the consumer, 12 bits
    typedef struct packed {
        logic  rd;    // one-cycle strobe
        chn_t  chn;   // tags of chn_count and up read back as zero
        page_t page;
        word_t word;
    } rd_req_t;

    // read response, 65 bits
    typedef struct packed {
        logic  valid;  // one cycle per request
        data_t data;
    } rd_rsp_t;

endpackage

`default_nettype wire
